// File: src.f
+incdir+verilog
verilog/vst_pkg.sv
verilog/vst_burst_if.sv
verilog/vst_addrgen.sv
verilog/vst_store_unit.sv
verilog/vst_top.sv
tb/vst_asserts.sv
tb/tb_vst_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vst_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_vst_top.sv
// Testbench for the vector store path
// Request table, lane driver and AXI slave model with random back-pressure
// Expected AW, W and done values built from the burst rules, watchdog
`timescale 1ns/1ps
`include "vst_consts.svh"

module tb_vst_top;

  localparam int unsigned num_rows        = 8;
  localparam int unsigned watchdog_cycles = 200 * num_rows + 200;

  typedef struct packed {
    vst_pkg::vid_t   id;
    vst_pkg::vaddr_t addr;
    vst_pkg::vl_t    vl;
    logic [3:0]      bursts;
  } req_row_t;

  // Columns: id, base address, vector length, expected AW bursts
  req_row_t req_table [num_rows] = '{
    '{3'd1, 32'h0000_1000, 8'd1,  4'd1},
    '{3'd2, 32'h0000_2000, 8'd2,  4'd1},
    '{3'd3, 32'h0000_2040, 8'd7,  4'd1},
    '{3'd4, 32'h0000_3000, 8'd8,  4'd1},
    '{3'd5, 32'h0000_3108, 8'd9,  4'd2},
    '{3'd6, 32'h0000_4000, 8'd15, 4'd2},
    '{3'd7, 32'h0000_5010, 8'd17, 4'd3},
    '{3'd0, 32'h0000_6000, 8'd3,  4'd1}
  };

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  logic               req_ready;
  vst_pkg::vid_t      req_id;
  vst_pkg::vaddr_t    req_addr;
  vst_pkg::vl_t       req_vl;
  vst_pkg::vaddr_t    aw_addr;
  vst_pkg::axi_len_t  aw_len;
  logic               aw_valid;
  logic               aw_ready;
  vst_pkg::beat_t     w_data;
  vst_pkg::strb_t     w_strb;
  logic               w_last;
  logic               w_valid;
  logic               w_ready;
  logic               b_valid;
  logic               b_ready;
  vst_pkg::elem_t     lane0_data;
  vst_pkg::elem_t     lane1_data;
  logic               lane0_valid;
  logic               lane1_valid;
  logic               lane_ready;
  logic               done_valid;
  vst_pkg::vid_t      done_id;

  // Expected traffic in the order it must appear
  vst_pkg::vaddr_t    exp_aw_addr [$];
  vst_pkg::axi_len_t  exp_aw_len [$];
  vst_pkg::beat_t     exp_w_data [$];
  vst_pkg::strb_t     exp_w_strb [$];
  logic               exp_w_last [$];
  logic               exp_b_last [$];
  vst_pkg::vid_t      exp_done_id [$];
  // Instructions the lanes still owe words for
  vst_pkg::vid_t      lane_id_q [$];
  int unsigned        lane_words_q [$];

  logic [31:0]        lfsr;
  int unsigned        lane_word;
  int unsigned        row_idx;
  int unsigned        aw_cnt;
  int unsigned        w_cnt;
  int unsigned        wlast_cnt;
  int unsigned        b_cnt;
  int unsigned        lane_cnt;
  int unsigned        done_credit;
  int unsigned        total_beats;
  int unsigned        table_bursts;
  // Handshakes seen at the falling edge, acted on after the next rising edge
  logic               req_fire;
  logic               aw_fire;
  logic               w_fire;
  logic               b_fire;
  logic               lane_fire;

  vst_top u_vst_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_id_i      (req_id),
    .req_addr_i    (req_addr),
    .req_vl_i      (req_vl),
    .aw_addr_o     (aw_addr),
    .aw_len_o      (aw_len),
    .aw_valid_o    (aw_valid),
    .aw_ready_i    (aw_ready),
    .w_data_o      (w_data),
    .w_strb_o      (w_strb),
    .w_last_o      (w_last),
    .w_valid_o     (w_valid),
    .w_ready_i     (w_ready),
    .b_valid_i     (b_valid),
    .b_ready_o     (b_ready),
    .lane0_data_i  (lane0_data),
    .lane1_data_i  (lane1_data),
    .lane0_valid_i (lane0_valid),
    .lane1_valid_i (lane1_valid),
    .lane_ready_o  (lane_ready),
    .done_valid_o  (done_valid),
    .done_id_o     (done_id)
  );

  bind vst_top vst_asserts u_vst_asserts (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_vl_i     (req_vl_i),
    .aw_addr_o    (aw_addr_o),
    .aw_len_o     (aw_len_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .w_data_o     (w_data_o),
    .w_strb_o     (w_strb_o),
    .w_last_o     (w_last_o),
    .w_valid_o    (w_valid_o),
    .w_ready_i    (w_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  task automatic take_bit(output logic bit_o);
    if (lfsr[0]) begin
      lfsr = (lfsr >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr = lfsr >> 1;
    end
    bit_o = lfsr[0];
  endtask

  // Element idx of an instruction, id in the top bits
  function automatic vst_pkg::elem_t lane_elem(input vst_pkg::vid_t id, input int unsigned idx);
    return {id, 29'(idx)};
  endfunction

  task automatic build_expected();
    int unsigned     rem;
    int unsigned     beats;
    int unsigned     elems;
    int unsigned     left;
    int unsigned     word;
    vst_pkg::vaddr_t addr;
    vst_pkg::vid_t   id;
    for (int unsigned r = 0; r < num_rows; r++) begin
      id           = req_table[r].id;
      addr         = req_table[r].addr;
      rem          = 32'(req_table[r].vl);
      word         = 0;
      table_bursts = table_bursts + 32'(req_table[r].bursts);
      while (rem > 0) begin
        // Two elements per beat, capped at the burst limit
        beats = (rem + 1) / 2;
        if (beats > `VST_MAX_BURST) begin
          beats = `VST_MAX_BURST;
        end
        elems = (rem < 2 * beats) ? rem : 2 * beats;
        exp_aw_addr.push_back(addr);
        exp_aw_len.push_back(vst_pkg::axi_len_t'(beats - 1));
        left = elems;
        for (int unsigned b = 0; b < beats; b++) begin
          exp_w_data.push_back({lane_elem(id, 2 * word + 1), lane_elem(id, 2 * word)});
          // Lone trailing element writes the low four bytes
          exp_w_strb.push_back((left >= 2) ? 8'hFF : 8'h0F);
          exp_w_last.push_back(b == beats - 1);
          left = (left >= 2) ? left - 2 : 0;
          word = word + 1;
        end
        exp_b_last.push_back(rem == elems);
        addr        = addr + 8 * beats;
        rem         = rem - elems;
        total_beats = total_beats + beats;
      end
      exp_done_id.push_back(id);
    end
  endtask

  task automatic check_idle_outputs();
    check_value("req_ready_o", 64'(req_ready), 64'd0);
    check_value("aw_valid_o", 64'(aw_valid), 64'd0);
    check_value("w_valid_o", 64'(w_valid), 64'd0);
    check_value("b_ready_o", 64'(b_ready), 64'd0);
    check_value("lane_ready_o", 64'(lane_ready), 64'd0);
    check_value("done_valid_o", 64'(done_valid), 64'd0);
  endtask

  // Runs 1 ns after the rising edge
  task automatic drive_inputs();
    logic        r0;
    logic        r1;
    int unsigned b_avail;
    if (lane_fire) begin
      lane0_valid = 1'b0;
      lane1_valid = 1'b0;
      lane_word   = lane_word + 1;
      if (lane_word == lane_words_q[0]) begin
        void'(lane_id_q.pop_front());
        void'(lane_words_q.pop_front());
        lane_word = 0;
      end
    end
    // Accepted request, lanes now owe its elements
    if (req_fire) begin
      lane_id_q.push_back(req_id);
      lane_words_q.push_back((32'(req_vl) + 1) / 2);
      row_idx = row_idx + 1;
    end
    if (row_idx < num_rows) begin
      req_valid = 1'b1;
      req_id    = req_table[row_idx].id;
      req_addr  = req_table[row_idx].addr;
      req_vl    = req_table[row_idx].vl;
    end else begin
      req_valid = 1'b0;
      req_id    = '0;
      req_addr  = '0;
      req_vl    = '0;
    end
    if (lane_id_q.size() > 0) begin
      lane0_data = lane_elem(lane_id_q[0], 2 * lane_word);
      lane1_data = lane_elem(lane_id_q[0], 2 * lane_word + 1);
      // A lane keeps its word valid until it is taken
      if (!lane0_valid) begin
        take_bit(lane0_valid);
      end
      if (!lane1_valid) begin
        take_bit(lane1_valid);
      end
    end else begin
      lane0_valid = 1'b0;
      lane1_valid = 1'b0;
    end
    // Slave ready about three cycles in four
    take_bit(r0);
    take_bit(r1);
    aw_ready = r0 || r1;
    take_bit(r0);
    take_bit(r1);
    w_ready = r0 || r1;
    // One B per burst once its AW and last W are both in
    if (b_fire) begin
      b_valid = 1'b0;
    end
    b_avail = ((aw_cnt < wlast_cnt) ? aw_cnt : wlast_cnt) - b_cnt;
    if (!b_valid && b_avail > 0) begin
      take_bit(b_valid);
    end
  endtask

  // Runs at the falling edge, where all outputs have settled
  task automatic sample_outputs();
    req_fire  = req_valid && req_ready;
    aw_fire   = aw_valid && aw_ready;
    w_fire    = w_valid && w_ready;
    b_fire    = b_valid && b_ready;
    lane_fire = lane_ready;
    if (aw_fire) begin
      if (exp_aw_addr.size() == 0) begin
        $display("AW handshake seen with no burst left to expect");
        abort_run();
      end
      check_value("aw_addr_o", 64'(aw_addr), 64'(exp_aw_addr.pop_front()));
      check_value("aw_len_o", 64'(aw_len), 64'(exp_aw_len.pop_front()));
      aw_cnt = aw_cnt + 1;
    end
    if (w_fire) begin
      if (exp_w_data.size() == 0) begin
        $display("W beat seen with no beat left to expect");
        abort_run();
      end
      check_value("w_data_o", 64'(w_data), 64'(exp_w_data.pop_front()));
      check_value("w_strb_o", 64'(w_strb), 64'(exp_w_strb.pop_front()));
      check_value("w_last_o", 64'(w_last), 64'(exp_w_last.pop_front()));
      w_cnt = w_cnt + 1;
      if (w_last) begin
        wlast_cnt = wlast_cnt + 1;
      end
    end
    if (lane_fire) begin
      lane_cnt = lane_cnt + 1;
    end
    // Checked before this cycle's B, so the pulse must trail its B
    if (done_valid) begin
      if (done_credit == 0 || exp_done_id.size() == 0) begin
        $display("Done pulse came before the final B of its request");
        abort_run();
      end
      check_value("done_id_o", 64'(done_id), 64'(exp_done_id.pop_front()));
      done_credit = done_credit - 1;
    end
    if (b_fire) begin
      if (exp_b_last.size() == 0) begin
        $display("B handshake seen with no burst outstanding");
        abort_run();
      end
      if (exp_b_last.pop_front()) begin
        done_credit = done_credit + 1;
      end
      b_cnt = b_cnt + 1;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_id       = '0;
    req_addr     = '0;
    req_vl       = '0;
    aw_ready     = 1'b0;
    w_ready      = 1'b0;
    b_valid      = 1'b0;
    lane0_data   = '0;
    lane1_data   = '0;
    lane0_valid  = 1'b0;
    lane1_valid  = 1'b0;
    lfsr         = 32'd70701;
    lane_word    = 0;
    row_idx      = 0;
    aw_cnt       = 0;
    w_cnt        = 0;
    wlast_cnt    = 0;
    b_cnt        = 0;
    lane_cnt     = 0;
    done_credit  = 0;
    total_beats  = 0;
    table_bursts = 0;
    req_fire     = 1'b0;
    aw_fire      = 1'b0;
    w_fire       = 1'b0;
    b_fire       = 1'b0;
    lane_fire    = 1'b0;
    build_expected();
    repeat (16) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    // First cycle out of reset stays quiet too
    @(negedge clk);
    check_idle_outputs();
    while (exp_done_id.size() > 0) begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      sample_outputs();
    end
    // No lane word lost or taken twice
    check_value("lane words", 64'(lane_cnt), 64'(total_beats));
    check_value("W beats", 64'(w_cnt), 64'(total_beats));
    check_value("AW bursts", 64'(aw_cnt), 64'(table_bursts));
    $display("Test passed");
    $finish;
  end

  // Watchdog sized from the request table
  initial begin
    #(watchdog_cycles * 4);
    $display("Timeout after %0d cycles with requests still pending", watchdog_cycles);
    abort_run();
  end

endmodule

// File: tb/vst_asserts.sv
// Concurrent assertions bound to the store path top level
// AW and W hold until ready, legal requests
`timescale 1ns/1ps

module vst_asserts (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               req_valid_i,
  input vst_pkg::vl_t       req_vl_i,
  input vst_pkg::vaddr_t    aw_addr_o,
  input vst_pkg::axi_len_t  aw_len_o,
  input logic               aw_valid_o,
  input logic               aw_ready_i,
  input vst_pkg::beat_t     w_data_o,
  input vst_pkg::strb_t     w_strb_o,
  input logic               w_last_o,
  input logic               w_valid_o,
  input logic               w_ready_i
);

  // AW stays up with a steady payload until taken
  aw_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o))
    else $error("AW valid dropped or its payload changed before ready");

  // Same rule on W
  w_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o)
      && $stable(w_last_o))
    else $error("W valid dropped or its payload changed before ready");

  // Zero length stores are never sent
  req_vl_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i |-> req_vl_i != '0)
    else $error("Store request with vector length zero");

endmodule

// File: verilog/vst_top.sv
// Vector store path top level
// Address generator and store unit joined by the burst descriptor link
// AXI AW, W and B channels and the lanes as plain ports
`timescale 1ns/1ps
`include "vst_consts.svh"

module vst_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vst_pkg::vid_t      req_id_i,
  input  vst_pkg::vaddr_t    req_addr_i,
  input  vst_pkg::vl_t       req_vl_i,
  // AXI AW
  output vst_pkg::vaddr_t    aw_addr_o,
  output vst_pkg::axi_len_t  aw_len_o,
  output logic               aw_valid_o,
  input  logic               aw_ready_i,
  // AXI W
  output vst_pkg::beat_t     w_data_o,
  output vst_pkg::strb_t     w_strb_o,
  output logic               w_last_o,
  output logic               w_valid_o,
  input  logic               w_ready_i,
  // AXI B
  input  logic               b_valid_i,
  output logic               b_ready_o,
  // Lanes, one port per lane
  input  vst_pkg::elem_t     lane0_data_i,
  input  vst_pkg::elem_t     lane1_data_i,
  input  logic               lane0_valid_i,
  input  logic               lane1_valid_i,
  output logic               lane_ready_o,
  // Completion
  output logic               done_valid_o,
  output vst_pkg::vid_t      done_id_o
);

  vst_pkg::elem_t [`VST_NR_LANES-1:0] lane_data;
  logic [`VST_NR_LANES-1:0]           lane_valid;

  assign lane_data[0]  = lane0_data_i;
  assign lane_data[1]  = lane1_data_i;
  assign lane_valid[0] = lane0_valid_i;
  assign lane_valid[1] = lane1_valid_i;

  vst_burst_if u_burst_if ();

  vst_addrgen u_addrgen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_id_i    (req_id_i),
    .req_addr_i  (req_addr_i),
    .req_vl_i    (req_vl_i),
    .aw_addr_o   (aw_addr_o),
    .aw_len_o    (aw_len_o),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .burst       (u_burst_if.gen)
  );

  vst_store_unit u_store_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .burst        (u_burst_if.wr),
    .lane_data_i  (lane_data),
    .lane_valid_i (lane_valid),
    .lane_ready_o (lane_ready_o),
    .w_data_o     (w_data_o),
    .w_strb_o     (w_strb_o),
    .w_last_o     (w_last_o),
    .w_valid_o    (w_valid_o),
    .w_ready_i    (w_ready_i),
    .b_valid_i    (b_valid_i),
    .b_ready_o    (b_ready_o),
    .done_valid_o (done_valid_o),
    .done_id_o    (done_id_o)
  );

endmodule

// File: verilog/vst_store_unit.sv
// Vector store unit
// Packs lane words into AXI W beats with strobe and last
// Commit queue of sent bursts, B handling and done reporting
`timescale 1ns/1ps
`include "vst_consts.svh"

module vst_store_unit (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Descriptors from the address generator
  vst_burst_if.wr                             burst,
  // Lane operands
  input  vst_pkg::elem_t [`VST_NR_LANES-1:0]  lane_data_i,
  input  logic [`VST_NR_LANES-1:0]            lane_valid_i,
  output logic                                lane_ready_o,
  // AXI W channel
  output vst_pkg::beat_t                      w_data_o,
  output vst_pkg::strb_t                      w_strb_o,
  output logic                                w_last_o,
  output logic                                w_valid_o,
  input  logic                                w_ready_i,
  // AXI B channel, response code ignored
  input  logic                                b_valid_i,
  output logic                                b_ready_o,
  // Instruction completion
  output logic                                done_valid_o,
  output vst_pkg::vid_t                       done_id_o
);

  localparam int unsigned depth      = `VST_COMMIT_DEPTH;
  localparam int unsigned ptr_w      = $clog2(depth);
  localparam int unsigned elem_bytes = `VST_ELEM_W / 8;

  // Position inside the current burst
  vst_pkg::axi_len_t beat_cnt_q;
  vst_pkg::vl_t      elem_cnt_q;
  vst_pkg::vl_t      elems_left;
  logic              two_elems;
  logic              w_fire;
  logic              burst_end;

  // Commit queue storage and control
  vst_pkg::vid_t     cq_id_q [depth];
  logic [depth-1:0]  cq_last_q;
  logic [ptr_w-1:0]  cq_wptr_q;
  logic [ptr_w-1:0]  cq_rptr_q;
  logic [ptr_w:0]    cq_cnt_q;
  logic              cq_full;
  logic              cq_push;
  logic              cq_pop;

  assign elems_left = burst.elems - elem_cnt_q;
  // Trailing odd element fills only the low half
  assign two_elems  = (elems_left >= vst_pkg::vl_t'(`VST_NR_LANES));

  // Lane 0 lands in the low half of the beat
  assign w_data_o  = vst_pkg::beat_t'(lane_data_i);
  assign w_strb_o  = two_elems ? '1 : vst_pkg::strb_t'({elem_bytes{1'b1}});
  assign w_last_o  = (beat_cnt_q == burst.beats);
  // Independent of wready, as AXI requires
  assign w_valid_o = burst.valid && (&lane_valid_i) && !cq_full;
  assign w_fire    = w_valid_o && w_ready_i;
  assign burst_end = w_fire && w_last_o;

  // One lane word per W beat
  assign lane_ready_o = w_fire;
  // Retire the descriptor on its final beat
  assign burst.ready  = burst_end;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
      elem_cnt_q <= '0;
    end else if (burst_end) begin
      beat_cnt_q <= '0;
      elem_cnt_q <= '0;
    end else if (w_fire) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      elem_cnt_q <= elem_cnt_q + vst_pkg::vl_t'(`VST_NR_LANES);
    end
  end

  // Every sent burst waits here for its B, oldest first
  assign cq_full   = (cq_cnt_q == (ptr_w+1)'(depth));
  assign cq_push   = burst_end;
  assign b_ready_o = (cq_cnt_q != '0);
  assign cq_pop    = b_valid_i && b_ready_o;

  always_ff @(posedge clk_i) begin
    if (cq_push) begin
      cq_id_q[cq_wptr_q]   <= burst.id;
      cq_last_q[cq_wptr_q] <= burst.last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cq_wptr_q <= '0;
      cq_rptr_q <= '0;
      cq_cnt_q  <= '0;
    end else begin
      if (cq_push) begin
        cq_wptr_q <= (cq_wptr_q == ptr_w'(depth - 1)) ? '0 : cq_wptr_q + 1'b1;
      end
      if (cq_pop) begin
        cq_rptr_q <= (cq_rptr_q == ptr_w'(depth - 1)) ? '0 : cq_rptr_q + 1'b1;
      end
      cq_cnt_q <= cq_cnt_q + (ptr_w+1)'(cq_push) - (ptr_w+1)'(cq_pop);
    end
  end

  // Done pulse one cycle after the B of a final burst
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_valid_o <= 1'b0;
    end else begin
      done_valid_o <= cq_pop && cq_last_q[cq_rptr_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (cq_pop) begin
      done_id_o <= cq_id_q[cq_rptr_q];
    end
  end

endmodule

// File: verilog/vst_addrgen.sv
// Vector store address generator
// Splits a store request into INCR bursts of up to four 8-byte beats
// Issues one AW and one burst descriptor per burst
`timescale 1ns/1ps
`include "vst_consts.svh"

module vst_addrgen (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer request
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vst_pkg::vid_t      req_id_i,
  input  vst_pkg::vaddr_t    req_addr_i,
  input  vst_pkg::vl_t       req_vl_i,
  // AXI AW channel, size 8 bytes and INCR implied
  output vst_pkg::vaddr_t    aw_addr_o,
  output vst_pkg::axi_len_t  aw_len_o,
  output logic               aw_valid_o,
  input  logic               aw_ready_i,
  // Descriptors towards the store unit
  vst_burst_if.gen           burst
);

  // Elements that fit in one full burst
  localparam int unsigned max_elems = `VST_NR_LANES * `VST_MAX_BURST;
  // Address step per beat as a shift
  localparam int unsigned beat_shift = $clog2(`VST_NR_LANES * `VST_ELEM_W / 8);

  vst_pkg::ag_state_e state_q;
  vst_pkg::ag_state_e state_d;
  logic               req_ready_q;
  logic               aw_sent_q;
  logic               desc_sent_q;
  vst_pkg::vid_t      id_q;
  vst_pkg::vaddr_t    addr_q;
  vst_pkg::vl_t       rem_q;

  logic [`VST_VL_W:0] beats_total;
  vst_pkg::axi_len_t  burst_beats;
  vst_pkg::vl_t       burst_elems;
  logic               final_burst;
  logic               req_fire;
  logic               aw_fire;
  logic               desc_fire;
  logic               aw_done;
  logic               desc_done;
  logic               burst_done;

  // Shape of the current burst from the remaining elements
  always_comb begin
    // Two elements per beat, rounded up
    beats_total = ({1'b0, rem_q} + 1'b1) >> 1;
    burst_beats = (beats_total > `VST_MAX_BURST) ? vst_pkg::axi_len_t'(`VST_MAX_BURST)
                                                 : vst_pkg::axi_len_t'(beats_total);
    final_burst = (rem_q <= max_elems);
    burst_elems = final_burst ? rem_q : vst_pkg::vl_t'(max_elems);
  end

  assign req_ready_o = req_ready_q;
  assign req_fire    = req_valid_i && req_ready_q;

  // AW and descriptor leave together but may be accepted apart
  assign aw_valid_o  = (state_q == vst_pkg::AG_BURST) && !aw_sent_q;
  assign aw_addr_o   = addr_q;
  assign aw_len_o    = burst_beats - 1'b1;
  assign burst.valid = (state_q == vst_pkg::AG_BURST) && !desc_sent_q;
  assign burst.beats = aw_len_o;
  assign burst.elems = burst_elems;
  assign burst.id    = id_q;
  assign burst.last  = final_burst;

  assign aw_fire    = aw_valid_o && aw_ready_i;
  assign desc_fire  = burst.valid && burst.ready;
  assign aw_done    = aw_sent_q || aw_fire;
  assign desc_done  = desc_sent_q || desc_fire;
  // Advance once both sides have taken the burst
  assign burst_done = (state_q == vst_pkg::AG_BURST) && aw_done && desc_done;

  always_comb begin
    state_d = state_q;
    if (req_fire) begin
      state_d = vst_pkg::AG_BURST;
    end else if (burst_done && final_burst) begin
      state_d = vst_pkg::AG_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= vst_pkg::AG_IDLE;
      req_ready_q <= 1'b0;
      aw_sent_q   <= 1'b0;
      desc_sent_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // Ready mirrors the idle state from the first cycle on
      req_ready_q <= (state_d == vst_pkg::AG_IDLE);
      if (req_fire || burst_done) begin
        aw_sent_q   <= 1'b0;
        desc_sent_q <= 1'b0;
      end else begin
        aw_sent_q   <= aw_done;
        desc_sent_q <= desc_done;
      end
    end
  end

  // Current instruction, next burst address and elements left
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      id_q   <= req_id_i;
      addr_q <= req_addr_i;
      rem_q  <= req_vl_i;
    end else if (burst_done) begin
      addr_q <= addr_q + (vst_pkg::vaddr_t'(burst_beats) << beat_shift);
      rem_q  <= rem_q - burst_elems;
    end
  end

endmodule

// File: verilog/vst_burst_if.sv
// Burst descriptor link between address generator and store unit
// One descriptor per AW burst, valid/ready handshake
`timescale 1ns/1ps

interface vst_burst_if;

  logic               valid;
  logic               ready;
  // Burst length minus one, same as AW len
  vst_pkg::axi_len_t  beats;
  // Valid elements carried by the burst
  vst_pkg::vl_t       elems;
  vst_pkg::vid_t      id;
  // Final burst of the instruction
  logic               last;

  // Address generator side
  modport gen (output valid, beats, elems, id, last, input ready);
  // Store unit side
  modport wr (input valid, beats, elems, id, last, output ready);

endinterface

// File: verilog/vst_pkg.sv
// Shared types of the vector store path
// Vector payload typedefs and the address generator state enum
`include "vst_consts.svh"

package vst_pkg;

  // Instruction id from the sequencer
  typedef logic [`VST_ID_W-1:0] vid_t;
  // Byte address
  typedef logic [`VST_ADDR_W-1:0] vaddr_t;
  // Element count
  typedef logic [`VST_VL_W-1:0] vl_t;
  // One lane element
  typedef logic [`VST_ELEM_W-1:0] elem_t;

  // One W beat, lane 0 in the low half
  typedef logic [`VST_NR_LANES*`VST_ELEM_W-1:0] beat_t;
  // Byte strobe of one W beat
  typedef logic [`VST_NR_LANES*`VST_ELEM_W/8-1:0] strb_t;
  // AXI burst length minus one
  typedef logic [7:0] axi_len_t;

  // Address generator states
  typedef enum logic {
    AG_IDLE,
    AG_BURST
  } ag_state_e;

endpackage

// File: verilog/vst_consts.svh
// Constants for the vector store path
// Lane count, element and address widths, burst limit and commit queue depth
`ifndef VST_CONSTS_SVH
`define VST_CONSTS_SVH

// Lanes delivering one element each per step
`define VST_NR_LANES 2
// Element width in bits
`define VST_ELEM_W 32
// Byte address width
`define VST_ADDR_W 32
// Vector length width in elements
`define VST_VL_W 8
// Instruction id width
`define VST_ID_W 3
// Most beats in one AW burst
`define VST_MAX_BURST 4
// Bursts that may wait for their B response
`define VST_COMMIT_DEPTH 8

`endif
